// File: Makefile
# Verilator build and run for the signal analyser front end

VERILATOR ?= verilator
TOP       ?= fas_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
+incdir+hdl
+incdir+dv
hdl/fas_types_pkg.sv
hdl/fir_coef_pkg.sv
hdl/fir_tap_line.sv
hdl/fir_half_mac.sv
hdl/fir_round_out.sv
hdl/sample_framer.sv
hdl/fas_top.sv
dv/fas_tb.sv

// File: dv/fas_tb_tests.svh
/* Directed tests */

// Outputs quiet and zero through reset and just after
task automatic reset_state();
  // Five rising edges see reset high
  repeat (4) begin
    @(negedge clk);
    check_eq(fir_valid, 0, "fir_valid in reset");
    check_eq(frame_valid, 0, "frame_valid in reset");
    check_eq(fir_d, 0, "fir_d in reset");
  end
  @(posedge clk);
  #10;
  rst = 1'b0;
  repeat (3) begin
    @(negedge clk);
    check_eq(fir_valid, 0, "fir_valid after reset");
    check_eq(frame_valid, 0, "frame_valid after reset");
    check_eq(fir_d, 0, "fir_d after reset");
  end
  for (int i = 0; i < `FAS_FRAME_LEN; i++) check_eq(frame[i], 0, "frame after reset");
endtask

// Single 0x4000 pulse walks through all 32 taps
task automatic impulse_response();
  clear_counts();
  repeat (31) send_sample('0);
  send_sample(16'sh4000);
  repeat (31) send_sample('0);
  drain_pipeline();  // Monitor checks the 3 cycle latency on every beat
  check_eq(beat_log.size(), `FAS_NUM_TAPS, "impulse beat count");
  for (int k = 0; k < `FAS_NUM_TAPS; k++) begin
    check_eq(beat_log[k], round_sum(longint'(FIR_COEFS[k]) * 16384), "impulse tap");
  end
endtask

task automatic random_stream();
  clear_counts();
  repeat (200) send_sample(16'($urandom));
  drain_pipeline();
  check_eq(beat_cnt, 200 - 31, "random stream beat count");
endtask

// Windows across the gap must not produce a beat
task automatic gap_restart();
  clear_counts();
  repeat (50) send_sample(16'($urandom));
  insert_gap();
  repeat (60) send_sample(16'($urandom));
  drain_pipeline();
  check_eq(beat_cnt, (50 - 31) + (60 - 31), "gap restart beat count");
endtask

// Only full frames are published and each gap restarts at slot 0
task automatic framing();
  clear_counts();
  repeat (64 + 31) send_sample(16'($urandom));  // Four frames
  insert_gap();
  repeat (20 + 31) send_sample(16'($urandom));  // One frame with four beats dropped
  insert_gap();
  repeat (10 + 31) send_sample(16'($urandom));  // Partial only
  insert_gap();
  repeat (16 + 31) send_sample(16'($urandom));  // One frame from slot 0
  drain_pipeline();
  check_eq(beat_cnt, 64 + 20 + 10 + 16, "framing beat count");
  check_eq(frame_cnt, 6, "frames published");
endtask

// File: dv/fas_tb.sv
/* Front end testbench */

`default_nettype none

`include "fas_defines.svh"

module fas_tb
  import fas_types_pkg::*;
  import fir_coef_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // Cycle budget per test including the drain
  localparam int RESET_CYC   = 12;
  localparam int IMPULSE_CYC = 72;   // 63 samples
  localparam int RANDOM_CYC  = 210;  // 200 samples
  localparam int GAP_CYC     = 120;  // 50 + gap + 60 samples
  localparam int FRAMING_CYC = 250;  // Four runs of 234 samples in all
  localparam int TEST_CYC    = RESET_CYC + IMPULSE_CYC + RANDOM_CYC + GAP_CYC + FRAMING_CYC;
  localparam int LIMIT_CYC   = 2 * TEST_CYC + 100;
  localparam int FIR_LATENCY = 3;    // Accept edge to the edge that sees fir_valid

  logic    clk;
  logic    rst;
  logic    data_valid;
  sample_t data;
  logic    fir_valid;
  sample_t fir_d;
  logic    frame_valid;
  frame_t  frame;

  // Reference model state
  sample_t hist [`FAS_NUM_TAPS];  // Index 31 is the newest input
  int      run_len;               // Consecutive accepted samples
  int      cyc;                   // Posedge count
  int      timeout_cnt;
  sample_t exp_q [$];             // Expected fir_d in order
  int      acc_q [$];             // Accept cycle of each expected beat

  // Output monitor state
  frame_t  frame_buf;
  frame_t  frame_exp;
  int      fill;                  // Beats in the frame being built
  logic    frame_due;             // Pulse expected on the next negedge
  int      beat_cnt;
  int      frame_cnt;
  sample_t beat_log [$];          // fir_d beats of the current test
  int      seed_val;

  fas_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  always #50 clk = ~clk;  // 100 ns period

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and the compare task
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure();
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_eq(input logic signed [63:0] got, input logic signed [63:0] exp,
                          input string what);
    if (got !== exp) begin
      $display("ERR time %0t: %s got %0d expected %0d", $time, what, got, exp);
      report_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Sum of products over the whole window with coefficient p at position p
  function automatic longint window_sum();
    longint s;
    s = 0;
    for (int p = 0; p < `FAS_NUM_TAPS; p++) begin
      s += longint'(hist[p]) * longint'(FIR_COEFS[p]);
    end
    return s;
  endfunction

  // Sign bit and bits 30..16 plus one LSB for negative sums
  function automatic sample_t round_sum(input longint s);
    logic [63:0] bits;
    sample_t     r;
    bits = s;
    r    = {bits[63], bits[`FAS_FRAC_SHIFT+`FAS_SAMPLE_W-2:`FAS_FRAC_SHIFT]};
    if (s < 0) r = r + 16'sd1;  // Wraps in 16 bits
    return r;
  endfunction

  // Inputs are stable here since they change 10 ns after the edge
  always @(posedge clk) begin
    cyc++;
    if (rst) begin
      run_len = 0;
      for (int i = 0; i < `FAS_NUM_TAPS; i++) hist[i] = '0;
    end else if (data_valid) begin
      for (int i = 0; i < `FAS_NUM_TAPS - 1; i++) hist[i] = hist[i+1];
      hist[`FAS_NUM_TAPS-1] = data;
      if (run_len < `FAS_NUM_TAPS) run_len++;
      if (run_len == `FAS_NUM_TAPS) begin  // Full window of one run
        exp_q.push_back(round_sum(window_sum()));
        acc_q.push_back(cyc);
      end
    end else begin
      run_len = 0;  // A gap means the next window needs 32 fresh samples
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output monitor sampling at the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : out_mon
    sample_t exp_d;
    int      acc_c;
    if (rst) begin
      fill      = 0;
      frame_due = 1'b0;
    end else begin
      // Pulse belongs to the 16th beat seen one cycle earlier
      check_eq(frame_valid, frame_due, "frame_valid pulse");
      if (frame_valid) begin
        for (int i = 0; i < `FAS_FRAME_LEN; i++) begin
          check_eq(frame[i], frame_exp[i], $sformatf("frame slot %0d", i));
        end
        frame_cnt++;
      end
      frame_due = 1'b0;
      if (fir_valid) begin
        if (exp_q.size() == 0) begin
          $display("fir_valid at time %0t without any full input window", $time);
          report_failure();
        end else begin
          exp_d = exp_q.pop_front();
          acc_c = acc_q.pop_front();
          check_eq(fir_d, exp_d, "fir_d");
          check_eq(cyc + 1 - acc_c, FIR_LATENCY, "fir latency");
          beat_cnt++;
          beat_log.push_back(fir_d);
          frame_buf[fill] = exp_d;
          fill++;
          if (fill == `FAS_FRAME_LEN) begin
            frame_exp = frame_buf;
            frame_due = 1'b1;
            fill      = 0;
          end
        end
      end else begin
        fill = 0;  // Partial frame dropped
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    timeout_cnt++;
    if (timeout_cnt > LIMIT_CYC) begin
      $display("Timeout: run still going after %0d clock cycles", LIMIT_CYC);
      report_failure();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic send_sample(input sample_t s);
    @(posedge clk);
    #10;
    data_valid = 1'b1;
    data       = s;
  endtask

  task automatic insert_gap();
    @(posedge clk);
    #10;
    data_valid = 1'b0;
    data       = '0;
  endtask

  // Stop input and wait for every expected beat and a last frame pulse
  task automatic drain_pipeline();
    insert_gap();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic clear_counts();
    beat_cnt  = 0;
    frame_cnt = 0;
    beat_log.delete();
  endtask

  `include "fas_tb_tests.svh"

  initial begin
    seed_val    = $urandom(58);
    clk         = 1'b0;
    rst         = 1'b1;
    data_valid  = 1'b0;
    data        = '0;
    cyc         = 0;
    timeout_cnt = 0;
    run_len     = 0;
    fill        = 0;
    frame_due   = 1'b0;
    clear_counts();
    reset_state();
    impulse_response();
    random_stream();
    gap_restart();
    framing();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/fas_defines.svh
/* Signal analyser front end constants */

`ifndef FAS_DEFINES_SVH
`define FAS_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

`define FAS_SAMPLE_W   16  // Input and filtered sample width
`define FAS_COEF_W     20  // Signed coefficient, 16 fraction bits
`define FAS_ACC_W      42  // 32 products of 36 bits plus headroom

//////////////////////////////////////////////////////////////////////
// Filter geometry
//////////////////////////////////////////////////////////////////////

`define FAS_NUM_TAPS   32  // Filter length
`define FAS_HALF_TAPS  16  // Taps per half MAC

// Fraction point of the accumulator
// Output takes bits FAS_FRAC_SHIFT+14 down to FAS_FRAC_SHIFT after the sign
`define FAS_FRAC_SHIFT 16

//////////////////////////////////////////////////////////////////////
// Framing
//////////////////////////////////////////////////////////////////////

`define FAS_FRAME_LEN  16  // Filter outputs per frame

`endif

// File: hdl/fas_top.sv
/* Signal analyser front end */

`default_nettype none

`include "fas_defines.svh"

module fas_top
  import fas_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    data_valid,   // Sample strobe, no back-pressure
  input  sample_t data,
  output logic    fir_valid,    // Filtered stream, 3 cycles behind the window
  output sample_t fir_d,
  output logic    frame_valid,  // 16 filtered samples ready
  output frame_t  frame
);

  half_taps_t low_taps;      // Window positions 0..15
  half_taps_t high_taps;     // Window positions 16..31
  logic       window_valid;
  acc_t       lo_sum;
  acc_t       hi_sum;

  //////////////////////////////////////////////////////////////////////
  // Filter pipeline
  //////////////////////////////////////////////////////////////////////

  fir_tap_line u_tap_line (
    .clk          (clk),
    .rst          (rst),
    .data_valid   (data_valid),
    .data         (data),
    .low_taps     (low_taps),
    .high_taps    (high_taps),
    .window_valid (window_valid)
  );

  // Both halves run in parallel on the same window
  fir_half_mac #(.FIRST_TAP(0)) u_mac_lo (
    .clk      (clk),
    .rst      (rst),
    .taps     (low_taps),
    .part_sum (lo_sum)
  );

  fir_half_mac #(.FIRST_TAP(`FAS_HALF_TAPS)) u_mac_hi (
    .clk      (clk),
    .rst      (rst),
    .taps     (high_taps),
    .part_sum (hi_sum)
  );

  fir_round_out u_round (
    .clk          (clk),
    .rst          (rst),
    .window_valid (window_valid),
    .lo_sum       (lo_sum),
    .hi_sum       (hi_sum),
    .fir_valid    (fir_valid),
    .fir_d        (fir_d)
  );

  // Framer listens to the same stream that leaves the top
  sample_framer u_framer (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

endmodule

`default_nettype wire

// File: hdl/fas_types_pkg.sv
/* Datapath types */

`default_nettype none

`include "fas_defines.svh"

package fas_types_pkg;

  // One stream sample, two's complement
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;

  // Full precision sum of products
  typedef logic signed [`FAS_ACC_W-1:0] acc_t;

  // Half of the filter window, index 0 is the oldest sample of the slice
  typedef sample_t half_taps_t [`FAS_HALF_TAPS];

  // One frame for the block transform
  // Slot 0 holds the first filter output of the frame
  typedef sample_t frame_t [`FAS_FRAME_LEN];

endpackage

`default_nettype wire

// File: hdl/fir_coef_pkg.sv
/* Low-pass FIR coefficients */

`default_nettype none

`include "fas_defines.svh"

package fir_coef_pkg;

  typedef logic signed [`FAS_COEF_W-1:0] coef_t;   // Q4.16
  typedef coef_t coef_table_t [`FAS_NUM_TAPS];

  // Symmetric table, entry k equals entry 31-k
  // Centre pair sits at 15 and 16
  localparam coef_table_t FIR_COEFS = '{
    20'hFFF9E,  // 0   -0.0015
    20'hFFF86,  // 1   -0.0019
    20'hFFFA7,  // 2   -0.0014
    20'h0003B,  // 3    0.0009
    20'h0014B,  // 4    0.0051
    20'h0024A,  // 5    0.0089
    20'h00222,  // 6    0.0083
    20'hFFFE4,  // 7   -0.0004
    20'hFFBC5,  // 8   -0.0165
    20'hFF7CA,  // 9   -0.0321
    20'hFF74E,  // 10  -0.0340
    20'hFFD74,  // 11  -0.0099
    20'h00B1A,  // 12   0.0434
    20'h01DAC,  // 13   0.1159
    20'h02F9E,  // 14   0.1860
    20'h03AA9,  // 15   0.2291, centre
    20'h03AA9,  // 16   0.2291, centre
    20'h02F9E,  // 17
    20'h01DAC,  // 18
    20'h00B1A,  // 19
    20'hFFD74,  // 20
    20'hFF74E,  // 21
    20'hFF7CA,  // 22
    20'hFFBC5,  // 23
    20'hFFFE4,  // 24
    20'h00222,  // 25
    20'h0024A,  // 26
    20'h0014B,  // 27
    20'h0003B,  // 28
    20'hFFFA7,  // 29
    20'hFFF86,  // 30
    20'hFFF9E   // 31
  };

endpackage

`default_nettype wire

// File: hdl/fir_half_mac.sv
/* FIR half multiply-accumulate */

`default_nettype none

`include "fas_defines.svh"

module fir_half_mac
  import fas_types_pkg::*;
  import fir_coef_pkg::*;
#(
  parameter int FIRST_TAP = 0  // Tap index of taps[0], 0 or 16
) (
  input  logic       clk,
  input  logic       rst,
  input  half_taps_t taps,      // Window slice from the tap line
  output acc_t       part_sum   // Registered, one cycle after the window
);

  acc_t sum_c;  // Adder tree result

  //////////////////////////////////////////////////////////////////////
  // Products and adder tree
  //////////////////////////////////////////////////////////////////////

  // Each 16x20 product is 36 bits, sign extended into the accumulator
  // Window position p uses FIR_COEFS[p], the table is symmetric
  always_comb begin
    sum_c = '0;
    for (int i = 0; i < `FAS_HALF_TAPS; i++) begin
      sum_c = sum_c + taps[i] * FIR_COEFS[FIRST_TAP + i];
    end
  end

  // Free running register, validity travels alongside in the round stage
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      part_sum <= '0;
    end else begin
      part_sum <= sum_c;
    end
  end

endmodule

`default_nettype wire

// File: hdl/fir_round_out.sv
/* FIR sum and rounding stage */

`default_nettype none

`include "fas_defines.svh"

module fir_round_out
  import fas_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    window_valid,  // From the tap line, two edges ahead of fir_valid
  input  acc_t    lo_sum,        // Taps 0..15
  input  acc_t    hi_sum,        // Taps 16..31
  output logic    fir_valid,
  output sample_t fir_d
);

  logic    valid_d;   // window_valid aligned with the partial sums
  acc_t    sum_c;     // Full filter sum
  sample_t trunc_c;   // Sign plus 15 integer bits
  logic    neg_c;

  //////////////////////////////////////////////////////////////////////
  // Combine and round
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sum_c   = lo_sum + hi_sum;
    neg_c   = sum_c[`FAS_ACC_W-1];
    trunc_c = {neg_c, sum_c[`FAS_FRAC_SHIFT + `FAS_SAMPLE_W - 2 : `FAS_FRAC_SHIFT]};
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_d   <= 1'b0;
      fir_valid <= 1'b0;
      fir_d     <= '0;
    end else begin
      valid_d   <= window_valid;
      fir_valid <= valid_d;
      // Negative sums get one LSB back, wraps in 16 bits
      fir_d     <= trunc_c + sample_t'(neg_c);
    end
  end

  // Output beat must trace back to a full window two edges earlier
  a_valid_aligned : assert property (@(posedge clk) disable iff (rst)
    fir_valid |-> $past(window_valid, 2))
    else $error("fir_valid without a matching window");

endmodule

`default_nettype wire

// File: hdl/fir_tap_line.sv
/* FIR sample delay line */

`default_nettype none

`include "fas_defines.svh"

module fir_tap_line
  import fas_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       data_valid,   // One sample per high cycle
  input  sample_t    data,
  output half_taps_t low_taps,     // Positions 0..15, oldest first
  output half_taps_t high_taps,    // Positions 16..31
  output logic       window_valid  // Window holds 32 samples of one run
);

  localparam int CNT_W = $clog2(`FAS_NUM_TAPS) + 1;

  sample_t          taps_q [`FAS_NUM_TAPS];  // Position 31 is the newest
  logic [CNT_W-1:0] run_cnt;                 // Consecutive accepted samples

  //////////////////////////////////////////////////////////////////////
  // Delay line and run counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `FAS_NUM_TAPS; i++) taps_q[i] <= '0;
      run_cnt      <= '0;
      window_valid <= 1'b0;
    end else begin
      if (data_valid) begin
        for (int i = 0; i < `FAS_NUM_TAPS - 1; i++) taps_q[i] <= taps_q[i+1];
        taps_q[`FAS_NUM_TAPS-1] <= data;
        // Saturate once the window is full
        if (run_cnt != CNT_W'(`FAS_NUM_TAPS)) run_cnt <= run_cnt + 1'b1;
      end else begin
        run_cnt <= '0;  // A gap restarts the run, samples stay
      end
      // This sample is at least the 32nd of the run
      window_valid <= data_valid && (run_cnt >= CNT_W'(`FAS_NUM_TAPS - 1));
    end
  end

  // Split the window between the two MAC halves
  always_comb begin
    for (int i = 0; i < `FAS_HALF_TAPS; i++) begin
      low_taps[i]  = taps_q[i];
      high_taps[i] = taps_q[i + `FAS_HALF_TAPS];
    end
  end

  a_run_cnt_max : assert property (@(posedge clk) disable iff (rst)
    run_cnt <= CNT_W'(`FAS_NUM_TAPS))
    else $error("tap line run counter above tap count");

endmodule

`default_nettype wire

// File: hdl/sample_framer.sv
/* Serial to parallel framer */

`default_nettype none

`include "fas_defines.svh"

module sample_framer
  import fas_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    fir_valid,
  input  sample_t fir_d,
  output logic    frame_valid,  // One cycle pulse per full frame
  output frame_t  frame
);

  localparam int SLOT_W = $clog2(`FAS_FRAME_LEN);
  localparam int LAST   = `FAS_FRAME_LEN - 1;

  logic [SLOT_W:0] slot_cnt;                  // Next free slot
  sample_t         slots [`FAS_FRAME_LEN-1];  // Last beat goes straight to frame

  //////////////////////////////////////////////////////////////////////
  // Slot storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fir_valid && slot_cnt != (SLOT_W+1)'(LAST)) begin
      slots[slot_cnt[SLOT_W-1:0]] <= fir_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slot counter and frame publish
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot_cnt    <= '0;
      frame_valid <= 1'b0;
      for (int i = 0; i < `FAS_FRAME_LEN; i++) frame[i] <= '0;
    end else begin
      frame_valid <= 1'b0;
      if (fir_valid) begin
        if (slot_cnt == (SLOT_W+1)'(LAST)) begin
          // 16th beat, copy out and start over
          for (int i = 0; i < LAST; i++) frame[i] <= slots[i];
          frame[LAST] <= fir_d;
          frame_valid <= 1'b1;
          slot_cnt    <= '0;
        end else begin
          slot_cnt <= slot_cnt + 1'b1;
        end
      end else begin
        slot_cnt <= '0;  // Gap drops a partial frame
      end
    end
  end

  a_pulse_single : assert property (@(posedge clk) disable iff (rst)
    frame_valid |=> !frame_valid)
    else $error("frame_valid held for two cycles");

  a_slot_range : assert property (@(posedge clk) disable iff (rst)
    slot_cnt < (SLOT_W+1)'(`FAS_FRAME_LEN))
    else $error("framer slot counter out of range");

endmodule

`default_nettype wire
